// File: include/ycbcr_cfg.svh
`ifndef YCBCR_CFG_SVH
`define YCBCR_CFG_SVH

// pixel geometry
`define YCC_PIX_W   8
`define YCC_LANES   8
`define YCC_WORD_W  (`YCC_LANES * `YCC_PIX_W)

// sram address width and groups per run
`define YCC_ADDR_W  11
`define YCC_GROUPS  16

// luma weights, scaled by 256
`define YCC_KY_R    77
`define YCC_KY_G    150
`define YCC_KY_B    29

// blue difference weights
`define YCC_KCB_R   (-43)
`define YCC_KCB_G   (-85)
`define YCC_KCB_B   128

// red difference weights
`define YCC_KCR_R   128
`define YCC_KCR_G   (-107)
`define YCC_KCR_B   (-21)

`define YCC_ROUND   128
`define YCC_OFFSET  128

`endif

// File: design/ycbcr_pkg.sv
`include "ycbcr_cfg.svh"

package ycbcr_pkg;

    // one sram word, seen raw on the ports or split into pixel lanes
    // lane 0 sits in the top bits
    typedef union packed {
        logic [`YCC_WORD_W-1:0]                 raw;
        logic [0:`YCC_LANES-1][`YCC_PIX_W-1:0]  lanes;
    } pixelWord_u;

endpackage

// File: design/planeFetcher.sv
`timescale 1ns/1ps
`include "ycbcr_cfg.svh"

module planeFetcher (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   enable,
    input  logic                   runDone,
    output logic [`YCC_ADDR_W-1:0] rdAddr,
    output logic                   fetchValid
);

    localparam int RunLen = 3 * `YCC_GROUPS;
    localparam logic [`YCC_ADDR_W-1:0] LastAddr = `YCC_ADDR_W'(RunLen - 1);

    localparam logic [1:0] StIdle  = 2'd0;
    localparam logic [1:0] StFetch = 2'd1;
    localparam logic [1:0] StDrain = 2'd2;

    logic [1:0] state;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= StIdle;
            rdAddr     <= '0;
            fetchValid <= 1'b0;
        end else begin
            // data for the address issued now shows up next cycle
            fetchValid <= (state == StFetch);
            case (state)
                StIdle: begin
                    if (enable) begin
                        state  <= StFetch;
                        rdAddr <= '0;
                    end
                end
                StFetch: begin
                    if (rdAddr == LastAddr) begin
                        state <= StDrain;
                    end else begin
                        rdAddr <= rdAddr + 1'b1;
                    end
                end
                StDrain: begin
                    // enable stays ignored until the last Cr word is out
                    if (runDone) begin
                        state <= StIdle;
                    end
                end
                default: begin
                    state <= StIdle;
                end
            endcase
        end
    end

    addrInRange: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == StFetch) |-> (rdAddr < RunLen)
    );

endmodule

// File: design/planeAligner.sv
`timescale 1ns/1ps
`include "ycbcr_cfg.svh"

module planeAligner (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 fetchValid,
    input  ycbcr_pkg::pixelWord_u rdData,
    output ycbcr_pkg::pixelWord_u rIn,
    output ycbcr_pkg::pixelWord_u gIn,
    output ycbcr_pkg::pixelWord_u bIn,
    output logic                 rgbValid
);

    // plane order within a group: R, G, B
    logic [1:0] plane;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            plane    <= 2'd0;
            rgbValid <= 1'b0;
        end else begin
            rgbValid <= fetchValid && (plane == 2'd2);
            if (fetchValid) begin
                plane <= (plane == 2'd2) ? 2'd0 : plane + 2'd1;
            end
        end
    end

    // plane holding registers
    always_ff @(posedge clk) begin
        if (fetchValid) begin
            case (plane)
                2'd0:    rIn <= rdData;
                2'd1:    gIn <= rdData;
                default: bIn <= rdData;
            endcase
        end
    end

    // groups are three words apart, so a triplet never repeats back to back
    singleValid: assert property (
        @(posedge clk) disable iff (!rst_n)
        rgbValid |=> !rgbValid
    );

endmodule

// File: design/colorConverter.sv
`timescale 1ns/1ps
`include "ycbcr_cfg.svh"

module colorConverter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   rgbValid,
    input  ycbcr_pkg::pixelWord_u  rIn,
    input  ycbcr_pkg::pixelWord_u  gIn,
    input  ycbcr_pkg::pixelWord_u  bIn,
    output logic [`YCC_ADDR_W-1:0] wrAddr,
    output ycbcr_pkg::pixelWord_u  wrData,
    output logic                   wen,
    output logic                   runDone,
    output logic                   valid
);

    import ycbcr_pkg::*;

    localparam int AccW   = `YCC_PIX_W + 10;
    localparam int Frac   = 8;
    localparam int PixMax = (1 << `YCC_PIX_W) - 1;
    localparam int RunLen = 3 * `YCC_GROUPS;
    localparam int GrpW   = $clog2(`YCC_GROUPS + 1);
    localparam logic [`YCC_ADDR_W-1:0] LastAddr  = `YCC_ADDR_W'(RunLen - 1);
    localparam logic [GrpW-1:0]        LastGroup = GrpW'(`YCC_GROUPS - 1);

    localparam logic [1:0] PhIdle = 2'd0;
    localparam logic [1:0] PhCb   = 2'd1;
    localparam logic [1:0] PhCr   = 2'd2;

    function automatic logic [`YCC_PIX_W-1:0] clampPix(input logic signed [AccW-1:0] v);
        logic [`YCC_PIX_W-1:0] res;
        if (v < 0) begin
            res = '0;
        end else if (v > PixMax) begin
            res = '1;
        end else begin
            res = v[`YCC_PIX_W-1:0];
        end
        return res;
    endfunction

    wire pixelWord_u yNext;
    wire pixelWord_u cbNext;
    wire pixelWord_u crNext;

    pixelWord_u yReg;
    pixelWord_u cbReg;
    pixelWord_u crReg;

    logic            cvtValid;
    logic [1:0]      wrPhase;
    logic [GrpW-1:0] groupCnt;

    for (genvar i = 0; i < `YCC_LANES; i++) begin : gLane
        logic signed [AccW-1:0] rS, gS, bS;
        logic signed [AccW-1:0] ySum, cbSum, crSum;

        assign rS = {{(AccW - `YCC_PIX_W){1'b0}}, rIn.lanes[i]};
        assign gS = {{(AccW - `YCC_PIX_W){1'b0}}, gIn.lanes[i]};
        assign bS = {{(AccW - `YCC_PIX_W){1'b0}}, bIn.lanes[i]};

        assign ySum  = AccW'(`YCC_KY_R * rS + `YCC_KY_G * gS + `YCC_KY_B * bS + `YCC_ROUND);
        assign cbSum = AccW'(`YCC_KCB_R * rS + `YCC_KCB_G * gS + `YCC_KCB_B * bS + `YCC_ROUND);
        assign crSum = AccW'(`YCC_KCR_R * rS + `YCC_KCR_G * gS + `YCC_KCR_B * bS + `YCC_ROUND);

        // arithmetic shift floors negative sums too
        assign yNext.lanes[i]  = clampPix(ySum >>> Frac);
        assign cbNext.lanes[i] = clampPix(AccW'((cbSum >>> Frac) + `YCC_OFFSET));
        assign crNext.lanes[i] = clampPix(AccW'((crSum >>> Frac) + `YCC_OFFSET));
    end

    always_ff @(posedge clk) begin
        if (rgbValid) begin
            yReg  <= yNext;
            cbReg <= cbNext;
            crReg <= crNext;
        end
    end

    // write word follows the phase, Y right after conversion
    always_ff @(posedge clk) begin
        if (cvtValid) begin
            wrData <= yReg;
        end else if (wrPhase == PhCb) begin
            wrData <= cbReg;
        end else if (wrPhase == PhCr) begin
            wrData <= crReg;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cvtValid <= 1'b0;
            wrPhase  <= PhIdle;
            wrAddr   <= '0;
            wen      <= 1'b1;
            groupCnt <= '0;
            runDone  <= 1'b0;
            valid    <= 1'b0;
        end else begin
            cvtValid <= rgbValid;
            valid    <= runDone;
            runDone  <= 1'b0;
            wen      <= 1'b1;
            if (!wen) begin
                wrAddr <= (wrAddr == LastAddr) ? '0 : wrAddr + 1'b1;
            end
            if (cvtValid) begin
                wen     <= 1'b0;
                wrPhase <= PhCb;
            end else if (wrPhase == PhCb) begin
                wen     <= 1'b0;
                wrPhase <= PhCr;
            end else if (wrPhase == PhCr) begin
                wen     <= 1'b0;
                wrPhase <= PhIdle;
                // last Cr of the run goes out together with runDone
                if (groupCnt == LastGroup) begin
                    groupCnt <= '0;
                    runDone  <= 1'b1;
                end else begin
                    groupCnt <= groupCnt + 1'b1;
                end
            end
        end
    end

    writeInRange: assert property (
        @(posedge clk) disable iff (!rst_n)
        !wen |-> (wrAddr < RunLen)
    );

    // aligner spacing must leave the Y/Cb/Cr sequence free for the next group
    noOverlap: assert property (
        @(posedge clk) disable iff (!rst_n)
        cvtValid |-> (wrPhase == PhIdle)
    );

endmodule

// File: design/ycbcrBlockTop.sv
`timescale 1ns/1ps
`include "ycbcr_cfg.svh"

module ycbcrBlockTop (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   enable,
    input  ycbcr_pkg::pixelWord_u  rdData,
    output logic [`YCC_ADDR_W-1:0] rdAddr,
    output logic [`YCC_ADDR_W-1:0] wrAddr,
    output ycbcr_pkg::pixelWord_u  wrData,
    output logic                   wen,
    output logic                   valid
);

    import ycbcr_pkg::*;

    logic       fetchValid;
    logic       rgbValid;
    logic       runDone;
    pixelWord_u rIn;
    pixelWord_u gIn;
    pixelWord_u bIn;

    planeFetcher uFetcher (
        .clk        (clk),
        .rst_n      (rst_n),
        .enable     (enable),
        .runDone    (runDone),
        .rdAddr     (rdAddr),
        .fetchValid (fetchValid)
    );

    planeAligner uAligner (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetchValid (fetchValid),
        .rdData     (rdData),
        .rIn        (rIn),
        .gIn        (gIn),
        .bIn        (bIn),
        .rgbValid   (rgbValid)
    );

    colorConverter uConverter (
        .clk      (clk),
        .rst_n    (rst_n),
        .rgbValid (rgbValid),
        .rIn      (rIn),
        .gIn      (gIn),
        .bIn      (bIn),
        .wrAddr   (wrAddr),
        .wrData   (wrData),
        .wen      (wen),
        .runDone  (runDone),
        .valid    (valid)
    );

endmodule

// File: tests/sramModel.sv
`timescale 1ns/1ps
`include "ycbcr_cfg.svh"

module sramModel (
    input  logic                   clk,
    input  logic [`YCC_ADDR_W-1:0] rdAddr,
    output ycbcr_pkg::pixelWord_u  rdData,
    input  logic [`YCC_ADDR_W-1:0] wrAddr,
    input  ycbcr_pkg::pixelWord_u  wrData,
    input  logic                   wen
);

    import ycbcr_pkg::*;

    localparam int Depth = 1 << `YCC_ADDR_W;

    // source planes and converted planes kept apart
    pixelWord_u inMem  [Depth];
    pixelWord_u outMem [Depth];

    // one-cycle read latency
    always @(posedge clk) begin
        rdData <= inMem[rdAddr];
    end

    // write port is active low
    always @(posedge clk) begin
        if (!wen) begin
            outMem[wrAddr] <= wrData;
        end
    end

endmodule

// File: tests/ycbcrBlockTb.sv
`timescale 1ns/1ps
`include "ycbcr_cfg.svh"

module ycbcrBlockTb;

    import ycbcr_pkg::*;

    localparam int RunLen = 3 * `YCC_GROUPS;
    localparam int Skew   = 10;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   enable;
    pixelWord_u             rdData;
    pixelWord_u             wrData;
    logic [`YCC_ADDR_W-1:0] rdAddr;
    logic [`YCC_ADDR_W-1:0] wrAddr;
    logic                   wen;
    logic                   valid;

    // R, G, B words of each group, in read order
    pixelWord_u  pixIn [RunLen];
    logic [31:0] lcgState;
    string       testName;
    int          valueErrors, flagErrors, timeoutErrors;
    int          writeIdx, validCount;
    logic        validPrev, wenPrev;

    ycbcrBlockTop dut (.*);
    sramModel uSram (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // kind 0 gives Y, 1 gives Cb, 2 gives Cr
    function automatic pixelWord_u refConvert(input pixelWord_u r, input pixelWord_u g,
                                              input pixelWord_u b, input int kind);
        pixelWord_u res;
        int         rv, gv, bv;
        int         sum;
        int         v;
        for (int i = 0; i < `YCC_LANES; i++) begin
            rv = int'(r.lanes[i]);
            gv = int'(g.lanes[i]);
            bv = int'(b.lanes[i]);
            case (kind)
                0:       sum = 77 * rv + 150 * gv + 29 * bv;
                1:       sum = 128 * bv - 43 * rv - 85 * gv;
                default: sum = 128 * rv - 107 * gv - 21 * bv;
            endcase
            // lifted above zero so integer division floors
            v = (sum + 128 + 65536) / 256 - 256 + ((kind == 0) ? 0 : 128);
            res.lanes[i] = (v < 0) ? 8'd0 : (v > 255) ? 8'd255 : 8'(v);
        end
        return res;
    endfunction

    function automatic pixelWord_u expectedAt(input int idx);
        int base;
        base = idx - idx % 3;
        return refConvert(pixIn[base], pixIn[base + 1], pixIn[base + 2], idx % 3);
    endfunction

    task automatic checkWord(input string name, input pixelWord_u expected,
                             input pixelWord_u actual);
        if (actual !== expected) begin
            valueErrors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected.raw, actual.raw);
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            flagErrors++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic finishRun();
        int total;
        total = valueErrors + flagErrors + timeoutErrors;
        $display("errors: value %0d, flag %0d, timeout %0d", valueErrors, flagErrors,
                 timeoutErrors);
        if (total == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    task automatic pulseEnable();
        @(posedge clk);
        #Skew;
        enable = 1'b1;
        @(posedge clk);
        #Skew;
        enable = 1'b0;
    endtask

    task automatic waitValid(input int limit);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!valid && n < limit);
        if (!valid) begin
            timeoutErrors++;
            $display("%s: valid never rose within %0d cycles", testName, limit);
        end
    endtask

    task automatic fillRandom(input int firstGroup);
        logic [31:0] hi;
        for (int i = 3 * firstGroup; i < RunLen; i++) begin
            lcgState = lcgNext(lcgState);
            hi       = lcgState;
            lcgState = lcgNext(lcgState);
            pixIn[i].raw = {hi, lcgState};
        end
    endtask

    // black, white, red, green and blue groups, then a clamping mix
    task automatic fillDirected();
        for (int i = 0; i < 15; i++) begin
            pixIn[i].raw = (i inside {3, 4, 5, 6, 10, 14}) ? '1 : '0;
        end
        // lanes at (0,0,255) and (255,0,0) push Cb and Cr past the top
        pixIn[15].raw = 64'hff00_ff00_ff80_00ff;
        pixIn[16].raw = 64'h00ff_ff00_0080_0040;
        pixIn[17].raw = 64'h00ff_00ff_ff00_ff20;
    endtask

    task automatic runAndCheck(input string name, input bit busyEnable);
        testName = name;
        for (int i = 0; i < RunLen; i++) begin
            uSram.inMem[i] = pixIn[i];
        end
        writeIdx   = 0;
        validCount = 0;
        pulseEnable();
        if (busyEnable) begin
            // lands mid-fetch
            repeat (20) @(posedge clk);
            pulseEnable();
        end
        waitValid(10 * RunLen);
        if (timeoutErrors == 0) begin
            // quiet tail long enough to expose a spurious second run
            repeat (3 * RunLen) @(posedge clk);
            checkFlag({name, " single valid"}, 1'b1, validCount == 1);
            checkFlag({name, " write count"}, 1'b1, writeIdx == RunLen);
            for (int i = 0; i < RunLen; i++) begin
                checkWord($sformatf("%s stored %0d", name, i), expectedAt(i),
                          uSram.outMem[i]);
            end
        end
    endtask

    // reset values, every write and the valid pulse
    always @(negedge clk) begin
        if (!rst_n) begin
            checkFlag("reset wen", 1'b1, wen);
            checkFlag("reset valid", 1'b0, valid);
        end else begin
            if (!wen) begin
                if (validCount != 0 || writeIdx >= RunLen) begin
                    flagErrors++;
                    $display("%s: unexpected write to address %0d", testName, wrAddr);
                end else begin
                    checkWord($sformatf("%s write %0d", testName, writeIdx),
                              expectedAt(writeIdx), wrData);
                end
                writeIdx++;
            end
            if (valid) begin
                validCount++;
                checkFlag({testName, " valid width"}, 1'b0, validPrev);
                checkFlag({testName, " valid after last write"}, 1'b1,
                          writeIdx == RunLen && !wenPrev);
            end
        end
        validPrev = valid;
        wenPrev   = wen;
    end

    initial begin
        lcgState      = 32'h26fd_1a9e;
        valueErrors   = 0;
        flagErrors    = 0;
        timeoutErrors = 0;
        writeIdx      = 0;
        validCount    = 0;
        testName      = "reset";
        enable        = 1'b0;
        rst_n         = 1'b0;
        repeat (10) @(posedge clk);
        #Skew;
        rst_n = 1'b1;
        fillDirected();
        fillRandom(6);
        runAndCheck("directed", 1'b1);
        if (timeoutErrors == 0) begin
            fillRandom(0);
            runAndCheck("random", 1'b0);
        end
        finishRun();
    end

endmodule

// File: ycbcrBlock.f
+incdir+include
design/ycbcr_pkg.sv
design/planeFetcher.sv
design/planeAligner.sv
design/colorConverter.sv
design/ycbcrBlockTop.sv
tests/sramModel.sv
tests/ycbcrBlockTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module ycbcrBlockTb \
    -f ycbcrBlock.f --Mdir obj_dir -o ycbcrSim

./obj_dir/ycbcrSim > sim.log 2>&1
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
